// File: Bender.yml
package:
  name: axil_reg_slave

sources:
  - files:
      - rtl/axil_regs_pkg.sv
      - rtl/reg_bank.sv
      - rtl/axil_write_channel.sv
      - rtl/axil_read_channel.sv
      - rtl/axil_reg_slave.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/axil_reg_checker.sv
      - tb/axil_reg_slave_assertions.sv
      - tb/axil_reg_slave_tb.sv

// File: rtl/axil_read_channel.sv
`timescale 1ns/1ps
`default_nettype none

module axil_read_channel (
  input  wire                              S_AXI_ACLK,
  input  wire                              S_AXI_ARESETN,
  input  wire axil_regs_pkg::addr_t        araddr,
  input  wire                              arvalid,
  output logic                             arready,
  output axil_regs_pkg::data_t             rdata,
  output axil_regs_pkg::axi_resp_e         rresp,
  output logic                             rvalid,
  input  wire                              rready,
  output axil_regs_pkg::reg_index_t        rd_index,
  input  wire axil_regs_pkg::data_t        rd_data
);

  import axil_regs_pkg::*;

  logic       arready_q;
  logic       rvalid_q;
  data_t      rdata_q;
  reg_index_t index_q;
  logic       start;
  logic       rd_accept;

  // A stalled R channel holds off the next address.
  assign start     = !arready_q && arvalid && (!rvalid_q || rready);
  assign rd_accept = arready_q && arvalid;  // R slot is already free here.

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      arready_q <= 1'b0;
    end else begin
      arready_q <= start;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (start) begin
      index_q <= araddr[addr_lsb +: index_width];  // Bank sees it next cycle.
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      rvalid_q <= 1'b0;
    end else if (rd_accept) begin
      rvalid_q <= 1'b1;
    end else if (rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // Data is held for as long as rvalid waits on rready.
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      rdata_q <= '0;
    end else if (rd_accept) begin
      rdata_q <= rd_data;
    end
  end

  assign arready  = arready_q;
  assign rvalid   = rvalid_q;
  assign rdata    = rdata_q;
  assign rresp    = resp_okay;
  assign rd_index = index_q;

endmodule

`default_nettype wire

// File: rtl/axil_reg_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axil_reg_slave (
  input  wire                              S_AXI_ACLK,
  input  wire                              S_AXI_ARESETN,
  input  wire axil_regs_pkg::addr_t        S_AXI_AWADDR,
  input  wire                              S_AXI_AWVALID,
  output wire                              S_AXI_AWREADY,
  input  wire axil_regs_pkg::data_t        S_AXI_WDATA,
  input  wire axil_regs_pkg::strb_t        S_AXI_WSTRB,
  input  wire                              S_AXI_WVALID,
  output wire                              S_AXI_WREADY,
  output wire axil_regs_pkg::axi_resp_e    S_AXI_BRESP,
  output wire                              S_AXI_BVALID,
  input  wire                              S_AXI_BREADY,
  input  wire axil_regs_pkg::addr_t        S_AXI_ARADDR,
  input  wire                              S_AXI_ARVALID,
  output wire                              S_AXI_ARREADY,
  output wire axil_regs_pkg::data_t        S_AXI_RDATA,
  output wire axil_regs_pkg::axi_resp_e    S_AXI_RRESP,
  output wire                              S_AXI_RVALID,
  input  wire                              S_AXI_RREADY
);

  import axil_regs_pkg::*;

  logic       wr_en;
  reg_index_t wr_index;
  data_t      wr_data;
  strb_t      wr_strb;
  reg_index_t rd_index;
  data_t      rd_data;

  axil_write_channel u_write_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (S_AXI_AWADDR),
    .awvalid       (S_AXI_AWVALID),
    .awready       (S_AXI_AWREADY),
    .wdata         (S_AXI_WDATA),
    .wstrb         (S_AXI_WSTRB),
    .wvalid        (S_AXI_WVALID),
    .wready        (S_AXI_WREADY),
    .bresp         (S_AXI_BRESP),
    .bvalid        (S_AXI_BVALID),
    .bready        (S_AXI_BREADY),
    .wr_en         (wr_en),
    .wr_index      (wr_index),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb)
  );

  axil_read_channel u_read_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .araddr        (S_AXI_ARADDR),
    .arvalid       (S_AXI_ARVALID),
    .arready       (S_AXI_ARREADY),
    .rdata         (S_AXI_RDATA),
    .rresp         (S_AXI_RRESP),
    .rvalid        (S_AXI_RVALID),
    .rready        (S_AXI_RREADY),
    .rd_index      (rd_index),
    .rd_data       (rd_data)
  );

  // Shared by both channels, write port and read mux.
  reg_bank u_reg_bank (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_en         (wr_en),
    .wr_index      (wr_index),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb),
    .rd_index      (rd_index),
    .rd_data       (rd_data)
  );

endmodule

`default_nettype wire

// File: rtl/axil_regs_pkg.sv
`default_nettype none

package axil_regs_pkg;

  localparam int data_width  = 32;
  localparam int addr_width  = 7;
  localparam int strb_width  = data_width / 8;
  localparam int addr_lsb    = 2;  // Byte offset bits below the index.
  localparam int index_width = 5;
  localparam int num_regs    = 1 << index_width;

  typedef logic [data_width-1:0]  data_t;
  typedef logic [addr_width-1:0]  addr_t;
  typedef logic [strb_width-1:0]  strb_t;
  typedef logic [index_width-1:0] reg_index_t;

  // Only OKAY of these AXI response codes is ever returned.
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } axi_resp_e;

endpackage

`default_nettype wire

// File: rtl/axil_write_channel.sv
`timescale 1ns/1ps
`default_nettype none

module axil_write_channel (
  input  wire                              S_AXI_ACLK,
  input  wire                              S_AXI_ARESETN,
  input  wire axil_regs_pkg::addr_t        awaddr,
  input  wire                              awvalid,
  output logic                             awready,
  input  wire axil_regs_pkg::data_t        wdata,
  input  wire axil_regs_pkg::strb_t        wstrb,
  input  wire                              wvalid,
  output logic                             wready,
  output axil_regs_pkg::axi_resp_e         bresp,
  output logic                             bvalid,
  input  wire                              bready,
  output logic                             wr_en,
  output axil_regs_pkg::reg_index_t        wr_index,
  output axil_regs_pkg::data_t             wr_data,
  output axil_regs_pkg::strb_t             wr_strb
);

  import axil_regs_pkg::*;

  logic       accept_q;
  logic       bvalid_q;
  reg_index_t index_q;
  logic       start;

  // Both channels valid and the B slot free, or freed on this edge.
  assign start = !accept_q && awvalid && wvalid && (!bvalid_q || bready);

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      accept_q <= 1'b0;
    end else begin
      accept_q <= start;  // One cycle pulse.
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (start) begin
      index_q <= awaddr[addr_lsb +: index_width];
    end
  end

  // Response stays up until the master takes it.
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      bvalid_q <= 1'b0;
    end else if (wr_en) begin
      bvalid_q <= 1'b1;
    end else if (bready) begin
      bvalid_q <= 1'b0;
    end
  end

  assign awready  = accept_q;
  assign wready   = accept_q;
  assign wr_en    = accept_q && awvalid && wvalid;  // Handshake on both channels.
  assign wr_index = index_q;
  assign wr_data  = wdata;
  assign wr_strb  = wstrb;
  assign bvalid   = bvalid_q;
  assign bresp    = resp_okay;

endmodule

`default_nettype wire

// File: rtl/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
  input  wire                              S_AXI_ACLK,
  input  wire                              S_AXI_ARESETN,
  input  wire                              wr_en,
  input  wire axil_regs_pkg::reg_index_t   wr_index,
  input  wire axil_regs_pkg::data_t        wr_data,
  input  wire axil_regs_pkg::strb_t        wr_strb,
  input  wire axil_regs_pkg::reg_index_t   rd_index,
  output axil_regs_pkg::data_t             rd_data
);

  import axil_regs_pkg::*;

  data_t regs [num_regs];
  data_t merged;

  // Strobed lanes take the new byte, the rest keep the old one.
  always_comb begin
    merged = regs[wr_index];
    for (int lane = 0; lane < strb_width; lane++) begin
      if (wr_strb[lane]) begin
        merged[lane*8 +: 8] = wr_data[lane*8 +: 8];
      end
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_index] <= merged;
    end
  end

  assign rd_data = regs[rd_index];  // Plain read mux.

endmodule

`default_nettype wire

// File: tb/axil_reg_checker.sv
`timescale 1ns/1ps
`default_nettype none

module axil_reg_checker (
  input  wire                              S_AXI_ACLK,
  input  wire                              S_AXI_ARESETN,
  input  wire axil_regs_pkg::addr_t        S_AXI_AWADDR,
  input  wire                              S_AXI_AWVALID,
  input  wire                              S_AXI_AWREADY,
  input  wire axil_regs_pkg::data_t        S_AXI_WDATA,
  input  wire axil_regs_pkg::strb_t        S_AXI_WSTRB,
  input  wire                              S_AXI_WVALID,
  input  wire                              S_AXI_WREADY,
  input  wire axil_regs_pkg::axi_resp_e    S_AXI_BRESP,
  input  wire                              S_AXI_BVALID,
  input  wire                              S_AXI_BREADY,
  input  wire axil_regs_pkg::addr_t        S_AXI_ARADDR,
  input  wire                              S_AXI_ARVALID,
  input  wire                              S_AXI_ARREADY,
  input  wire axil_regs_pkg::data_t        S_AXI_RDATA,
  input  wire axil_regs_pkg::axi_resp_e    S_AXI_RRESP,
  input  wire                              S_AXI_RVALID,
  input  wire                              S_AXI_RREADY,
  input  wire axil_regs_pkg::data_t        exp_rdata,
  output int                               error_count,
  output int                               read_count
);

  import axil_regs_pkg::*;

  data_t      model [num_regs];
  data_t      model_rdata;
  data_t      held_rdata;
  logic       r_stalled;
  reg_index_t rd_reg;
  reg_index_t wr_reg;

  function automatic data_t merge_lanes(data_t old_word, data_t new_word, strb_t strb);
    data_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic flag_error(string msg);
    error_count++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  initial begin
    error_count = 0;
    read_count  = 0;
    r_stalled   = 1'b0;
  end

  always @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      for (int i = 0; i < num_regs; i++) begin
        model[i] = '0;
      end
      r_stalled = 1'b0;
    end else begin
      if (S_AXI_RVALID && S_AXI_RREADY) begin
        read_count++;
        if (S_AXI_RDATA !== model_rdata) begin
          flag_error($sformatf("reg %0d read %h, model holds %h", rd_reg, S_AXI_RDATA,
                               model_rdata));
        end
        if (S_AXI_RDATA !== exp_rdata) begin
          flag_error($sformatf("reg %0d read %h, table expects %h", rd_reg, S_AXI_RDATA,
                               exp_rdata));
        end
        if (S_AXI_RRESP !== resp_okay) begin
          flag_error($sformatf("RRESP is %b, not OKAY", S_AXI_RRESP));
        end
      end
      if (r_stalled && S_AXI_RDATA !== held_rdata) begin
        flag_error($sformatf("RDATA moved from %h to %h while stalled", held_rdata,
                             S_AXI_RDATA));
      end
      if (S_AXI_BVALID && S_AXI_BREADY && S_AXI_BRESP !== resp_okay) begin
        flag_error($sformatf("BRESP is %b, not OKAY", S_AXI_BRESP));
      end
      if (S_AXI_AWREADY && S_AXI_BVALID && !S_AXI_BREADY) begin
        flag_error("write address taken while B response is stalled");
      end
      // Read captures the bank before a write on the same edge.
      if (S_AXI_ARVALID && S_AXI_ARREADY) begin
        rd_reg      = S_AXI_ARADDR[addr_lsb +: index_width];
        model_rdata = model[rd_reg];
      end
      if (S_AXI_AWVALID && S_AXI_AWREADY && S_AXI_WVALID && S_AXI_WREADY) begin
        wr_reg        = S_AXI_AWADDR[addr_lsb +: index_width];
        model[wr_reg] = merge_lanes(model[wr_reg], S_AXI_WDATA, S_AXI_WSTRB);
      end
      r_stalled  = S_AXI_RVALID && !S_AXI_RREADY;
      held_rdata = S_AXI_RDATA;
    end
  end

endmodule

`default_nettype wire

// File: tb/axil_reg_slave_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module axil_reg_slave_assertions (
  input wire                           S_AXI_ACLK,
  input wire                           S_AXI_ARESETN,
  input wire                           addr_ready,
  input wire                           data_ready,
  input wire                           resp_valid,
  input wire                           resp_ready,
  input wire axil_regs_pkg::axi_resp_e resp
);

  import axil_regs_pkg::*;

  int fail_count = 0;

  ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    addr_ready == data_ready)
    else begin $error("address and data ready differ"); fail_count++; end

  resp_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    resp_valid && !resp_ready |=> resp_valid)
    else begin $error("response valid dropped before ready"); fail_count++; end

  resp_is_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    resp_valid |-> resp == resp_okay)
    else begin $error("response code is not OKAY"); fail_count++; end

  // Cleared on the first reset edge.
  quiet_in_reset: assert property (@(posedge S_AXI_ACLK)
    !S_AXI_ARESETN |=> !addr_ready && !data_ready && !resp_valid)
    else begin $error("ready or valid high during reset"); fail_count++; end

endmodule

`default_nettype wire

// File: tb/axil_reg_slave_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axil_reg_slave_tb;

  import axil_regs_pkg::*;

  typedef enum logic [1:0] {
    op_read,
    op_write,
    op_write_stall  // Issued while the previous B is still held.
  } op_e;

  logic      S_AXI_ACLK;
  logic      S_AXI_ARESETN;
  addr_t     awaddr;
  logic      awvalid;
  logic      awready;
  data_t     wdata;
  strb_t     wstrb;
  logic      wvalid;
  logic      wready;
  axi_resp_e bresp;
  logic      bvalid;
  logic      bready;
  addr_t     araddr;
  logic      arvalid;
  logic      arready;
  data_t     rdata;
  axi_resp_e rresp;
  logic      rvalid;
  logic      rready;
  data_t     exp_rdata;
  int        checker_errors;
  int        read_count;
  int        total_errors;
  int        num_reads;
  integer    seed;
  logic      table_ready;

  op_e   tbl_op    [$];
  addr_t tbl_addr  [$];
  data_t tbl_data  [$];
  strb_t tbl_strb  [$];
  data_t tbl_exp   [$];
  int    tbl_delay [$];

  tb_clock_gen u_clock_gen (.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN));

  axil_reg_slave DUT (
    .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
    .S_AXI_AWADDR(awaddr), .S_AXI_AWVALID(awvalid), .S_AXI_AWREADY(awready),
    .S_AXI_WDATA(wdata), .S_AXI_WSTRB(wstrb), .S_AXI_WVALID(wvalid), .S_AXI_WREADY(wready),
    .S_AXI_BRESP(bresp), .S_AXI_BVALID(bvalid), .S_AXI_BREADY(bready),
    .S_AXI_ARADDR(araddr), .S_AXI_ARVALID(arvalid), .S_AXI_ARREADY(arready),
    .S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp), .S_AXI_RVALID(rvalid), .S_AXI_RREADY(rready)
  );

  axil_reg_checker u_checker (
    .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
    .S_AXI_AWADDR(awaddr), .S_AXI_AWVALID(awvalid), .S_AXI_AWREADY(awready),
    .S_AXI_WDATA(wdata), .S_AXI_WSTRB(wstrb), .S_AXI_WVALID(wvalid), .S_AXI_WREADY(wready),
    .S_AXI_BRESP(bresp), .S_AXI_BVALID(bvalid), .S_AXI_BREADY(bready),
    .S_AXI_ARADDR(araddr), .S_AXI_ARVALID(arvalid), .S_AXI_ARREADY(arready),
    .S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp), .S_AXI_RVALID(rvalid), .S_AXI_RREADY(rready),
    .exp_rdata(exp_rdata), .error_count(checker_errors), .read_count(read_count)
  );

  bind axil_write_channel axil_reg_slave_assertions write_checks (
    .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN), .addr_ready(awready),
    .data_ready(wready), .resp_valid(bvalid), .resp_ready(bready), .resp(bresp)
  );

  bind axil_read_channel axil_reg_slave_assertions read_checks (
    .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN), .addr_ready(arready),
    .data_ready(arready), .resp_valid(rvalid), .resp_ready(rready), .resp(rresp)
  );

  task automatic add_entry(op_e op, addr_t addr, data_t data, strb_t strb, data_t expv,
                           int delay);
    tbl_op.push_back(op);
    tbl_addr.push_back(addr);
    tbl_data.push_back(data);
    tbl_strb.push_back(strb);
    tbl_exp.push_back(expv);
    tbl_delay.push_back(delay);
    if (op == op_read) begin
      num_reads++;
    end
  endtask

  task automatic build_table();
    data_t word [num_regs];
    add_entry(op_read, 7'h00, '0, '0, '0, 0);  // Reset values.
    add_entry(op_read, 7'h44, '0, '0, '0, 1);
    add_entry(op_read, 7'h7c, '0, '0, '0, 2);
    for (int r = 0; r < num_regs; r += 5) begin
      word[r] = $random(seed);
      add_entry(op_write, addr_t'(r * 4), word[r], 4'hf, '0, r % 4);
    end
    for (int r = 0; r < num_regs; r += 5) begin
      add_entry(op_read, addr_t'(r * 4), '0, '0, word[r], (r + 1) % 4);
    end
    add_entry(op_read, 7'h04, '0, '0, '0, 0);
    add_entry(op_read, 7'h44, '0, '0, '0, 0);
    add_entry(op_read, 7'h7c, '0, '0, '0, 0);
    add_entry(op_write, 7'h0c, 32'h11223344, 4'b1111, '0, 0);  // Byte lanes.
    add_entry(op_write, 7'h0c, 32'haabbccdd, 4'b0001, '0, 1);
    add_entry(op_read, 7'h0c, '0, '0, 32'h112233dd, 0);
    add_entry(op_write, 7'h0c, 32'h55667788, 4'b0110, '0, 0);
    add_entry(op_read, 7'h0c, '0, '0, 32'h116677dd, 2);
    add_entry(op_write, 7'h0c, 32'h99887766, 4'b1000, '0, 3);
    add_entry(op_read, 7'h0c, '0, '0, 32'h996677dd, 0);
    add_entry(op_write, 7'h19, 32'hcafef00d, 4'b1111, '0, 0);  // Low address bits.
    add_entry(op_read, 7'h1b, '0, '0, 32'hcafef00d, 1);
    add_entry(op_read, 7'h18, '0, '0, 32'hcafef00d, 0);
    add_entry(op_write, 7'h1a, 32'h000000ee, 4'b0001, '0, 0);
    add_entry(op_read, 7'h1b, '0, '0, 32'hcafef0ee, 0);
    word[8] = $random(seed);
    word[9] = $random(seed);
    add_entry(op_write, 7'h20, word[8], 4'hf, '0, 0);
    add_entry(op_write_stall, 7'h24, word[9], 4'hf, '0, 3);
    add_entry(op_read, 7'h20, '0, '0, word[8], 3);
    add_entry(op_read, 7'h24, '0, '0, word[9], 3);
    add_entry(op_read, 7'h28, '0, '0, word[10], 0);
  endtask

  task automatic present_write(int i);
    awaddr  = tbl_addr[i];
    wdata   = tbl_data[i];
    wstrb   = tbl_strb[i];
    awvalid = 1'b1;
    wvalid  = 1'b1;
  endtask

  task automatic finish_write();
    while (!awready) @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic take_b(int delay);
    while (!bvalid) @(negedge S_AXI_ACLK);
    repeat (delay) @(negedge S_AXI_ACLK);
    bready = 1'b1;
    @(negedge S_AXI_ACLK);
    bready = 1'b0;
  endtask

  task automatic run_read(int i);
    araddr    = tbl_addr[i];
    exp_rdata = tbl_exp[i];
    arvalid   = 1'b1;
    while (!arready) @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    arvalid = 1'b0;
    while (!rvalid) @(negedge S_AXI_ACLK);
    repeat (tbl_delay[i]) @(negedge S_AXI_ACLK);
    rready = 1'b1;
    @(negedge S_AXI_ACLK);
    rready = 1'b0;
  endtask

  initial begin
    wait (table_ready === 1'b1);
    repeat ((tbl_op.size() + 10) * 12) @(posedge S_AXI_ACLK);
    $display("Timeout: the run did not finish within %0d cycles", (tbl_op.size() + 10) * 12);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    seed        = 32'h420d;
    num_reads   = 0;
    table_ready = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    exp_rdata   = '0;
    build_table();
    table_ready = 1'b1;
    wait (S_AXI_ARESETN === 1'b1);
    @(negedge S_AXI_ACLK);
    for (int i = 0; i < tbl_op.size(); i++) begin
      case (tbl_op[i])
        op_read: run_read(i);
        op_write: begin
          present_write(i);
          finish_write();
          if (i + 1 >= tbl_op.size() || tbl_op[i + 1] != op_write_stall) begin
            take_b(tbl_delay[i]);
          end
        end
        default: begin
          present_write(i);  // Parked behind the held response.
          repeat (tbl_delay[i]) @(negedge S_AXI_ACLK);
          take_b(0);
          finish_write();
          take_b(0);
        end
      endcase
    end
    repeat (4) @(negedge S_AXI_ACLK);
    total_errors = checker_errors + DUT.u_write_channel.write_checks.fail_count
                 + DUT.u_read_channel.read_checks.fail_count;
    if (read_count != num_reads) begin
      $display("Only %0d of %0d reads completed on the bus", read_count, num_reads);
    end
    $display("Reads checked: %0d of %0d, errors: %0d", read_count, num_reads, total_errors);
    if (total_errors == 0 && read_count == num_reads) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic S_AXI_ACLK,
  output logic S_AXI_ARESETN
);

  initial begin
    S_AXI_ACLK = 1'b0;
    forever #10 S_AXI_ACLK = ~S_AXI_ACLK;  // 20 ns period.
  end

  // Five reset edges, released on a falling edge.
  initial begin
    S_AXI_ARESETN = 1'b0;
    repeat (5) @(posedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    S_AXI_ARESETN = 1'b1;
  end

endmodule

`default_nettype wire

// File: vlog.f
rtl/axil_regs_pkg.sv
rtl/reg_bank.sv
rtl/axil_write_channel.sv
rtl/axil_read_channel.sv
rtl/axil_reg_slave.sv
tb/tb_clock_gen.sv
tb/axil_reg_checker.sv
tb/axil_reg_slave_assertions.sv
tb/axil_reg_slave_tb.sv
